// ==== include/cipher_cfg.svh ====
// ##########################################################
// Word geometry for the cipher engine. Letters are coded
// 1 = a through 26 = z, and the index width must cover LEN
// ##########################################################
`ifndef CIPHER_CFG_SVH
`define CIPHER_CFG_SVH

// Letters per word
`define CIPHER_STRING_LEN 5

// Bits per coded letter, also the width of a shift
`define CIPHER_LETTER_W 5

// Letters in the alphabet, the rotation modulus
`define CIPHER_ALPHABET_SIZE 26

// Bits of a letter position
`define CIPHER_INDEX_W 3

`endif

// ==== source/cipher_text_pkg.sv ====
// ##########################################################
// Text types and letter arithmetic. Shifts must be reduced
// below 26 before rotate_letter is called
// ##########################################################
`include "cipher_cfg.svh"

package cipher_text_pkg;

	typedef logic [`CIPHER_LETTER_W-1:0] letter_t; // 1 = a .. 26 = z
	typedef logic [`CIPHER_LETTER_W-1:0] shift_t;  // Raw 0..31, reduced when used
	typedef logic [`CIPHER_INDEX_W-1:0] index_t;   // Position 0..4

	// One word seen flat or per letter, position 0 in the top bits
	typedef union packed
	{
		logic [`CIPHER_STRING_LEN*`CIPHER_LETTER_W-1:0] flat;
		letter_t [0:`CIPHER_STRING_LEN-1] letters;
	} string_u;

	// Shift or key letter modulo 26, so z gives 0
	function automatic shift_t reduce_shift(input shift_t raw);
		if (raw >= `CIPHER_ALPHABET_SIZE)
			return shift_t'(raw - `CIPHER_ALPHABET_SIZE);
		return raw;
	endfunction

	// Rotate a coded letter around the alphabet; non-letters untouched
	function automatic letter_t rotate_letter(input letter_t value, input shift_t amount,
		input logic decode);
		logic [`CIPHER_LETTER_W:0] wide; // One spare bit for the wrap
		if (value == '0 || value > `CIPHER_ALPHABET_SIZE)
			return value;
		if (decode)
			wide = {1'b0, value} + `CIPHER_ALPHABET_SIZE - {1'b0, amount}; // Lift before subtract
		else
			wide = {1'b0, value} + {1'b0, amount};
		if (wide > `CIPHER_ALPHABET_SIZE)
			wide = wide - `CIPHER_ALPHABET_SIZE; // Back into 1..26
		return letter_t'(wide[`CIPHER_LETTER_W-1:0]);
	endfunction

endpackage

// ==== source/cipher_mode_pkg.sv ====
// ##########################################################
// Mode types. Method code 3 has no name and acts as pass
// ##########################################################
package cipher_mode_pkg;

	// Which word lands in the result
	typedef enum logic [1:0]
	{
		method_pass     = 2'd0, // Text copied unchanged
		method_caesar   = 2'd1, // One shift for every letter
		method_vigenere = 2'd2  // Shift per position from the key
	} method_e;

	// Rotation sense
	typedef enum logic
	{
		dir_encode = 1'b0, // Forward around the alphabet
		dir_decode = 1'b1  // Backward
	} direction_e;

endpackage

// ==== source/letter_loader.sv ====
// ##########################################################
// Five-slot entry register. Loads past the fifth are
// dropped until clear, and clear beats a same-cycle load
// ##########################################################
`timescale 1ns/1ps
`include "cipher_cfg.svh"

module letter_loader
(
	input  logic                      clock,
	input  logic                      resetn,
	input  cipher_text_pkg::letter_t  letter_in,
	input  logic                      load,
	input  logic                      clear,
	output cipher_text_pkg::string_u  text
);

	// Next free slot, stops at five
	cipher_text_pkg::index_t fill;

	logic full;
	assign full = (fill == `CIPHER_STRING_LEN);

	always_ff @(posedge clock)
	begin
		if (!resetn || clear)
		begin
			text.flat <= '0; // Empty word
			fill <= '0;
		end
		else if (load && !full)
		begin
			text.letters[fill] <= letter_in; // Slot 0 first, top bits
			fill <= fill + 1'b1;
		end
	end

endmodule

// ==== source/cipher_sequencer.sv ====
// ##########################################################
// Run control. go counts only while idle; letters go out
// one per cycle from a snapshot, done 7 cycles after go
// ##########################################################
`timescale 1ns/1ps
`include "cipher_cfg.svh"

module cipher_sequencer
(
	input  logic                      clock,
	input  logic                      resetn,
	input  logic                      go,
	input  cipher_text_pkg::string_u  text,
	output logic                      start,
	output logic                      busy,
	output cipher_text_pkg::letter_t  letter,
	output cipher_text_pkg::index_t   position,
	output logic                      letter_valid,
	output logic                      done
);

	localparam cipher_text_pkg::index_t last_position =
		cipher_text_pkg::index_t'(`CIPHER_STRING_LEN - 1);

	cipher_text_pkg::string_u snap; // Text frozen for the run
	logic [1:0] tail;               // Cycles left until the last result settles

	// Same cycle as go, so the units latch before letter 0 arrives
	assign start = go && !busy;

	assign letter = snap.letters[position];

	always_ff @(posedge clock)
	begin
		if (start)
			snap <= text;
	end

	always_ff @(posedge clock)
	begin
		if (!resetn)
		begin
			busy <= 1'b0;
			letter_valid <= 1'b0;
			position <= '0;
			tail <= 2'd0;
			done <= 1'b0;
		end
		else
		begin
			done <= (tail == 2'd2); // Lands one cycle after the last unit result
			if (start)
			begin
				busy <= 1'b1;
				letter_valid <= 1'b1;
				position <= '0;
			end
			else if (letter_valid)
			begin
				if (position == last_position)
				begin
					letter_valid <= 1'b0;
					tail <= 2'd2; // Unit stage, then assembler write
				end
				else
					position <= position + 1'b1;
			end
			if (tail != 2'd0)
				tail <= tail - 1'b1;
			if (tail == 2'd1)
				busy <= 1'b0; // Drops after the done cycle
		end
	end

endmodule

// ==== source/caesar_unit.sv ====
// ##########################################################
// Caesar stage. Shift and direction are taken at start and
// held for the run; one letter per cycle, one cycle latency
// ##########################################################
`timescale 1ns/1ps

module caesar_unit
(
	input  logic                         clock,
	input  logic                         resetn,
	input  logic                         start,
	input  cipher_text_pkg::shift_t      shift,
	input  cipher_mode_pkg::direction_e  direction,
	input  cipher_text_pkg::letter_t     letter,
	input  cipher_text_pkg::index_t      position,
	input  logic                         letter_valid,
	output cipher_text_pkg::letter_t     out_letter,
	output cipher_text_pkg::index_t      out_position,
	output logic                         out_valid
);

	cipher_text_pkg::shift_t shift_q;          // Already below 26
	cipher_mode_pkg::direction_e direction_q;

	always_ff @(posedge clock)
	begin
		if (!resetn)
		begin
			direction_q <= cipher_mode_pkg::dir_encode;
			out_valid <= 1'b0;
		end
		else
		begin
			if (start)
				direction_q <= direction;
			out_valid <= letter_valid;
		end
	end

	always_ff @(posedge clock)
	begin
		if (start)
			shift_q <= cipher_text_pkg::reduce_shift(shift); // 26..31 fold down
		if (letter_valid)
		begin
			out_letter <= cipher_text_pkg::rotate_letter(letter, shift_q,
				direction_q == cipher_mode_pkg::dir_decode);
			out_position <= position; // Travels with its letter
		end
	end

endmodule

// ==== source/vigenere_unit.sv ====
// ##########################################################
// Vigenere stage. The key word is taken at start; key
// letter z or a zero slot means no shift at that position
// ##########################################################
`timescale 1ns/1ps

module vigenere_unit
(
	input  logic                         clock,
	input  logic                         resetn,
	input  logic                         start,
	input  cipher_text_pkg::string_u     key,
	input  cipher_mode_pkg::direction_e  direction,
	input  cipher_text_pkg::letter_t     letter,
	input  cipher_text_pkg::index_t      position,
	input  logic                         letter_valid,
	output cipher_text_pkg::letter_t     out_letter,
	output cipher_text_pkg::index_t      out_position,
	output logic                         out_valid
);

	cipher_text_pkg::string_u key_q;
	cipher_mode_pkg::direction_e direction_q;
	cipher_text_pkg::shift_t key_shift;

	// Key letter lined up with the presented position
	assign key_shift = cipher_text_pkg::reduce_shift(key_q.letters[position]);

	always_ff @(posedge clock)
	begin
		if (!resetn)
		begin
			direction_q <= cipher_mode_pkg::dir_encode;
			out_valid <= 1'b0;
		end
		else
		begin
			if (start)
				direction_q <= direction;
			out_valid <= letter_valid;
		end
	end

	always_ff @(posedge clock)
	begin
		if (start)
			key_q <= key; // Whole word, same packing as the text
		if (letter_valid)
		begin
			out_letter <= cipher_text_pkg::rotate_letter(letter, key_shift,
				direction_q == cipher_mode_pkg::dir_decode);
			out_position <= position;
		end
	end

endmodule

// ==== source/output_assembler.sv ====
// ##########################################################
// Result builder. Method is taken at start; result keeps
// its old letters until the next run overwrites them
// ##########################################################
`timescale 1ns/1ps

module output_assembler
(
	input  logic                       clock,
	input  logic                       resetn,
	input  logic                       start,
	input  cipher_mode_pkg::method_e   method,
	input  cipher_text_pkg::letter_t   letter,
	input  cipher_text_pkg::index_t    position,
	input  logic                       letter_valid,
	input  cipher_text_pkg::letter_t   caesar_letter,
	input  cipher_text_pkg::index_t    caesar_position,
	input  logic                       caesar_valid,
	input  cipher_text_pkg::letter_t   vigenere_letter,
	input  cipher_text_pkg::index_t    vigenere_position,
	input  logic                       vigenere_valid,
	output cipher_text_pkg::string_u   result
);

	cipher_mode_pkg::method_e method_q;

	// Plain letter delayed to line up with the unit outputs
	cipher_text_pkg::letter_t pass_letter;
	cipher_text_pkg::index_t pass_position;
	logic pass_valid;

	always_ff @(posedge clock)
	begin
		if (letter_valid)
		begin
			pass_letter <= letter;
			pass_position <= position;
		end
	end

	always_ff @(posedge clock)
	begin
		if (!resetn)
		begin
			method_q <= cipher_mode_pkg::method_pass;
			pass_valid <= 1'b0;
			result.flat <= '0;
		end
		else
		begin
			if (start)
				method_q <= method;
			pass_valid <= letter_valid;
			case (method_q)
				cipher_mode_pkg::method_caesar:
					if (caesar_valid)
						result.letters[caesar_position] <= caesar_letter;
				cipher_mode_pkg::method_vigenere:
					if (vigenere_valid)
						result.letters[vigenere_position] <= vigenere_letter;
				default: // Pass, and code 3
					if (pass_valid)
						result.letters[pass_position] <= pass_letter;
			endcase
		end
	end

endmodule

// ==== source/cipher_top.sv ====
// ##########################################################
// Cipher engine top. Strobes are one cycle wide; go is
// ignored while busy, and result is final when done pulses
// ##########################################################
`timescale 1ns/1ps

module cipher_top
(
	input  logic                         clock,
	input  logic                         resetn,
	input  cipher_text_pkg::letter_t     letter_in,
	input  logic                         load,
	input  logic                         clear,
	input  cipher_text_pkg::shift_t      shift,
	input  cipher_text_pkg::string_u     key,
	input  cipher_mode_pkg::direction_e  direction,
	input  cipher_mode_pkg::method_e     method,
	input  logic                         go,
	output cipher_text_pkg::string_u     text,
	output cipher_text_pkg::string_u     result,
	output logic                         busy,
	output logic                         done
);

	logic start;

	// Sequencer to both units and the assembler
	cipher_text_pkg::letter_t seq_letter;
	cipher_text_pkg::index_t seq_position;
	logic seq_valid;

	// Unit results
	cipher_text_pkg::letter_t caesar_letter;
	cipher_text_pkg::index_t caesar_position;
	logic caesar_valid;
	cipher_text_pkg::letter_t vigenere_letter;
	cipher_text_pkg::index_t vigenere_position;
	logic vigenere_valid;

	letter_loader loader_i
	(
		.clock(clock), .resetn(resetn), .letter_in(letter_in),
		.load(load), .clear(clear), .text(text)
	);

	cipher_sequencer sequencer_i
	(
		.clock(clock), .resetn(resetn), .go(go), .text(text),
		.start(start), .busy(busy), .letter(seq_letter), .position(seq_position),
		.letter_valid(seq_valid), .done(done)
	);

	caesar_unit caesar_i
	(
		.clock(clock), .resetn(resetn), .start(start), .shift(shift),
		.direction(direction), .letter(seq_letter), .position(seq_position),
		.letter_valid(seq_valid), .out_letter(caesar_letter),
		.out_position(caesar_position), .out_valid(caesar_valid)
	);

	vigenere_unit vigenere_i
	(
		.clock(clock), .resetn(resetn), .start(start), .key(key),
		.direction(direction), .letter(seq_letter), .position(seq_position),
		.letter_valid(seq_valid), .out_letter(vigenere_letter),
		.out_position(vigenere_position), .out_valid(vigenere_valid)
	);

	output_assembler assembler_i
	(
		.clock(clock), .resetn(resetn), .start(start), .method(method),
		.letter(seq_letter), .position(seq_position), .letter_valid(seq_valid),
		.caesar_letter(caesar_letter), .caesar_position(caesar_position),
		.caesar_valid(caesar_valid), .vigenere_letter(vigenere_letter),
		.vigenere_position(vigenere_position), .vigenere_valid(vigenere_valid),
		.result(result)
	);

endmodule

// ==== verification/tb_cipher_model.svh ====
// ##########################################################
// Reference model, checks and tests, included inside
// tb_cipher_top and driving its signals directly
// ##########################################################
`ifndef TB_CIPHER_MODEL_SVH
`define TB_CIPHER_MODEL_SVH

// Expected word from the cipher rules
function automatic cipher_text_pkg::string_u expected_result(
	input cipher_text_pkg::string_u plain, input cipher_text_pkg::shift_t amount_in,
	input cipher_text_pkg::string_u key_word, input cipher_mode_pkg::direction_e dir,
	input cipher_mode_pkg::method_e how);
	cipher_text_pkg::string_u word;
	int amount;
	int value;
	int i;
	word = plain;
	for (i = 0; i < `CIPHER_STRING_LEN; i++)
	begin
		value = int'(plain.letters[i]);
		case (how)
			cipher_mode_pkg::method_caesar: amount = int'(amount_in) % `CIPHER_ALPHABET_SIZE;
			cipher_mode_pkg::method_vigenere: amount = int'(key_word.letters[i]) % 26; // z is 0
			default: amount = 0; // Pass and code 3
		endcase
		if (dir == cipher_mode_pkg::dir_decode)
			amount = `CIPHER_ALPHABET_SIZE - amount; // Back by n is forward by 26 - n
		if (value >= 1 && value <= `CIPHER_ALPHABET_SIZE)
			word.letters[i] = cipher_text_pkg::letter_t'((value - 1 + amount) % 26 + 1);
	end
	return word;
endfunction

task automatic compare_word(input cipher_text_pkg::string_u got,
	input cipher_text_pkg::string_u want, input string what);
	if (got !== want)
	begin
		error_count++;
		$display("mismatch at %0t ns: %s read %h, expected %h", $time, what, got.flat, want.flat);
	end
endtask

task automatic compare_flags(input logic got_busy, input logic got_done,
	input logic want_busy, input logic want_done, input string what);
	if (got_busy !== want_busy || got_done !== want_done)
	begin
		error_count++;
		$display("mismatch at %0t ns: %s busy %b done %b, expected %b %b", $time, what,
			got_busy, got_done, want_busy, want_done);
	end
endtask

// One step to just after the next rising edge
task automatic next_cycle();
	@(posedge clock);
	#1;
endtask

function automatic cipher_text_pkg::string_u random_word();
	cipher_text_pkg::string_u word;
	int i;
	for (i = 0; i < `CIPHER_STRING_LEN; i++)
		word.letters[i] = cipher_text_pkg::letter_t'($urandom_range(26, 1));
	return word;
endfunction

// Clear, then five loads in slot order
task automatic load_word(input cipher_text_pkg::string_u word);
	int i;
	next_cycle();
	clear = 1'b1;
	for (i = 0; i < `CIPHER_STRING_LEN; i++)
	begin
		next_cycle();
		clear = 1'b0;
		load = 1'b1;
		letter_in = word.letters[i];
	end
	next_cycle();
	load = 1'b0;
	loaded_word = word;
endtask

// One go, returns once the compare process has seen done
task automatic run_cipher(input cipher_text_pkg::shift_t amount,
	input cipher_text_pkg::string_u key_word, input cipher_mode_pkg::direction_e dir,
	input cipher_mode_pkg::method_e how);
	int runs_before;
	runs_before = compared_runs;
	expected_word = expected_result(loaded_word, amount, key_word, dir, how);
	next_cycle();
	shift = amount;
	key = key_word;
	direction = dir;
	method = how;
	go = 1'b1;
	next_cycle();
	go = 1'b0;
	wait (compared_runs == runs_before + 1);
endtask

task automatic finish_test(input string name, input int errors_before);
	tests_run++;
	if (error_count == errors_before)
	begin
		tests_passed++;
		$display("test %0d %s: ok", tests_run, name);
	end
	else
		$display("test %0d %s: %0d errors", tests_run, name, error_count - errors_before);
endtask

`endif

// ==== verification/tb_cipher_tests.svh ====
// ##########################################################
// Test list, included inside tb_cipher_top after the model
// ##########################################################
`ifndef TB_CIPHER_TESTS_SVH
`define TB_CIPHER_TESTS_SVH

// Loads past the fifth, then clear, and clear beating a same-cycle load
task automatic check_loading();
	cipher_text_pkg::string_u word;
	cipher_text_pkg::string_u zero;
	cipher_text_pkg::string_u first;
	int i;
	int errors_before;
	errors_before = error_count;
	zero = '0;
	word = random_word();
	first = '0;
	first.letters[0] = word.letters[0];
	next_cycle();
	clear = 1'b1;
	for (i = 0; i < 9; i++) // Enough extras to wrap a counter that never stops
	begin
		next_cycle();
		clear = 1'b0;
		load = 1'b1;
		letter_in = (i < 5) ? word.letters[i] : 5'd13; // Sixth on are dropped
	end
	next_cycle();
	load = 1'b0;
	@(negedge clock);
	compare_word(text, word, "text after extra loads");
	next_cycle();
	clear = 1'b1; // Plain clear
	next_cycle();
	clear = 1'b0;
	load = 1'b1;
	letter_in = word.letters[0]; // Back in slot 0, word not full
	next_cycle();
	clear = 1'b1;
	letter_in = 5'd1; // Load still high
	@(negedge clock);
	compare_word(text, first, "text after clear and one load");
	next_cycle();
	clear = 1'b0;
	load = 1'b0;
	@(negedge clock);
	compare_word(text, zero, "text after clear with load");
	loaded_word = zero;
	finish_test("load and clear", errors_before);
endtask

task automatic check_caesar_encode();
	cipher_text_pkg::string_u word;
	int errors_before;
	errors_before = error_count;
	word = random_word();
	word.letters[4] = 5'd26; // z wraps for any shift but 0
	load_word(word);
	run_cipher(cipher_text_pkg::shift_t'($urandom_range(31, 0)), '0,
		cipher_mode_pkg::dir_encode, cipher_mode_pkg::method_caesar);
	finish_test("caesar encode", errors_before);
endtask

// Encode, reload the coded word, decode back
task automatic check_caesar_decode();
	cipher_text_pkg::string_u word;
	cipher_text_pkg::string_u coded;
	cipher_text_pkg::shift_t amount;
	int errors_before;
	errors_before = error_count;
	amount = cipher_text_pkg::shift_t'($urandom_range(31, 0));
	word = random_word();
	word.letters[1] = '0;                                      // Below the alphabet
	word.letters[3] = cipher_text_pkg::letter_t'($urandom_range(31, 27)); // Above it
	coded = expected_result(word, amount, '0, cipher_mode_pkg::dir_encode,
		cipher_mode_pkg::method_caesar);
	load_word(word);
	run_cipher(amount, '0, cipher_mode_pkg::dir_encode, cipher_mode_pkg::method_caesar);
	load_word(coded);
	run_cipher(amount, '0, cipher_mode_pkg::dir_decode, cipher_mode_pkg::method_caesar);
	compare_word(result, word, "caesar round trip");
	finish_test("caesar decode", errors_before);
endtask

task automatic check_vigenere();
	cipher_text_pkg::string_u word;
	cipher_text_pkg::string_u coded;
	cipher_text_pkg::string_u key_word;
	int errors_before;
	errors_before = error_count;
	word = random_word();
	key_word = random_word();
	key_word.letters[2] = 5'd26; // Key z, no shift here
	coded = expected_result(word, '0, key_word, cipher_mode_pkg::dir_encode,
		cipher_mode_pkg::method_vigenere);
	load_word(word);
	run_cipher('0, key_word, cipher_mode_pkg::dir_encode, cipher_mode_pkg::method_vigenere);
	load_word(coded);
	run_cipher('0, key_word, cipher_mode_pkg::dir_decode, cipher_mode_pkg::method_vigenere);
	compare_word(result, word, "vigenere round trip");
	finish_test("vigenere", errors_before);
endtask

task automatic check_pass(input logic [1:0] code);
	cipher_text_pkg::string_u word;
	int errors_before;
	errors_before = error_count;
	word = random_word();
	word.letters[0] = 5'd30;
	load_word(word);
	run_cipher(cipher_text_pkg::shift_t'($urandom_range(31, 1)), random_word(),
		cipher_mode_pkg::dir_encode, cipher_mode_pkg::method_e'(code));
	compare_word(result, word, "pass result against loaded word");
	finish_test($sformatf("pass code %0d", code), errors_before);
endtask

// Busy over cycles 1 to 7, done in 7, retried go ignored
task automatic check_timing();
	int cyc;
	int errors_before;
	errors_before = error_count;
	load_word(random_word());
	expected_word = expected_result(loaded_word, '0, '0, cipher_mode_pkg::dir_encode,
		cipher_mode_pkg::method_pass);
	next_cycle();
	method = cipher_mode_pkg::method_pass;
	go = 1'b1; // Cycle 0
	for (cyc = 1; cyc <= 9; cyc++)
	begin
		next_cycle();
		go = (cyc == 3 || cyc == 7); // Retries while busy
		@(negedge clock);
		compare_flags(busy, done, cyc <= 7, cyc == 7, $sformatf("cycle %0d", cyc));
	end
	finish_test("timing", errors_before);
endtask

`endif

// ==== verification/tb_cipher_top.sv ====
// ##########################################################
// Testbench for cipher_top. Inputs move 1 ns after the
// rising edge and outputs are read on the falling edge
// ##########################################################
`timescale 1ns/1ps
`include "cipher_cfg.svh"

module tb_cipher_top;

	localparam int num_tests = 12;
	localparam int timeout_cycles = 40 * num_tests; // Each run needs under 40

	logic clock;
	logic resetn;
	cipher_text_pkg::letter_t letter_in;
	logic load;
	logic clear;
	cipher_text_pkg::shift_t shift;
	cipher_text_pkg::string_u key;
	cipher_mode_pkg::direction_e direction;
	cipher_mode_pkg::method_e method;
	logic go;
	cipher_text_pkg::string_u text;
	cipher_text_pkg::string_u result;
	logic busy;
	logic done;

	cipher_text_pkg::string_u loaded_word;   // Word last put into text
	cipher_text_pkg::string_u expected_word; // Set before each go
	int error_count = 0;
	int compared_runs = 0;                   // Done pulses checked so far
	int tests_run = 0;
	int tests_passed = 0;
	int cycle_count = 0;

	cipher_top dut_i
	(
		.clock(clock), .resetn(resetn), .letter_in(letter_in), .load(load),
		.clear(clear), .shift(shift), .key(key), .direction(direction),
		.method(method), .go(go), .text(text), .result(result),
		.busy(busy), .done(done)
	);

	`include "tb_cipher_model.svh"

	`include "tb_cipher_tests.svh"

	initial
	begin
		clock = 1'b0;
		forever
			#10 clock = ~clock; // 20 ns period
	end

	// Hard stop for a run that never finishes
	always @(posedge clock)
	begin
		cycle_count++;
		if (cycle_count >= timeout_cycles)
		begin
			$display("timeout after %0d cycles, a run never completed", timeout_cycles);
			$display("Test failed");
			$finish;
		end
	end

	// Result check on every done
	initial
	begin
		forever
		begin
			@(negedge clock);
			if (done === 1'b1)
			begin
				compare_word(result, expected_word, "result at done");
				compared_runs++;
			end
		end
	end

	initial
	begin
		void'($urandom(32'ha8c8d182));
		resetn = 1'b0;
		letter_in = '0;
		load = 1'b0;
		clear = 1'b0;
		shift = '0;
		key = '0;
		direction = cipher_mode_pkg::dir_encode;
		method = cipher_mode_pkg::method_pass;
		go = 1'b0;
		loaded_word = '0;
		expected_word = '0;
		repeat (4) @(posedge clock);
		#1 resetn = 1'b1;
		check_loading();
		repeat (4) check_caesar_encode();
		repeat (2) check_caesar_decode();
		repeat (2) check_vigenere();
		check_pass(2'd0);
		check_pass(2'd3); // Unnamed code behaves as pass
		check_timing();
		$display("%0d of %0d tests ok, %0d errors", tests_passed, tests_run, error_count);
		if (error_count == 0 && tests_run == num_tests)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule

// ==== cipher_top.f ====
+incdir+include
+incdir+verification
source/cipher_text_pkg.sv
source/cipher_mode_pkg.sv
source/letter_loader.sv
source/cipher_sequencer.sv
source/caesar_unit.sv
source/vigenere_unit.sv
source/output_assembler.sv
source/cipher_top.sv
verification/tb_cipher_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the cipher testbench with Verilator and runs it from the project root.
# The run fails on a build error or when the log holds the fail message.

verilator --binary --timing -Wno-fatal --top-module tb_cipher_top -f cipher_top.f \
	-o sim_cipher > build.log 2>&1 \
	&& ./obj_dir/sim_cipher > sim.log 2>&1 \
	|| { echo "build or simulation error, see build.log and sim.log"; exit 1; }

grep -q "Test failed" sim.log \
	&& { echo "simulation FAILED, see sim.log"; exit 1; } \
	|| { echo "simulation passed"; exit 0; }
